// File: sources.f
src/stream_pkg.sv
src/stream_frame_mux.sv
src/stream_skid_buffer.sv
src/frame_stats.sv
src/stream_mux_top.sv
test/tb_clock_gen.sv
test/stream_mux_tb.sv

// File: src/frame_stats.sv
/*
  beat pass-through with per-frame statistics. counters wrap at COUNT_WIDTH.
  a last beat is held back while the previous summary is still waiting.
  stat_ready is the early ready of a skid buffer and is registered here.
*/

`default_nettype none

module frame_stats (
    input  wire                                   clk,
    input  wire                                   rst,

    input  wire                                   buf_valid,
    input  wire  stream_pkg::beat_t               buf_beat,
    output logic                                  buf_ready,

    output logic [stream_pkg::DATA_WIDTH-1:0]     out_tdata,
    output logic [stream_pkg::KEEP_WIDTH-1:0]     out_tkeep,
    output logic                                  out_tvalid,
    output logic                                  out_tlast,
    output logic                                  out_tuser,
    output logic [stream_pkg::SEL_WIDTH-1:0]      out_tsrc,
    input  wire                                   out_tready,

    output logic                                  stat_valid,
    output stream_pkg::frame_summary_t            stat_summary,
    input  wire                                   stat_ready
);

    logic [stream_pkg::COUNT_WIDTH-1:0] beat_cnt;
    logic [stream_pkg::COUNT_WIDTH-1:0] byte_cnt;
    logic [stream_pkg::COUNT_WIDTH-1:0] beat_bytes;
    logic                               err_acc;

    // mirrors the summary buffer's own registered ready
    logic stat_ready_reg;

    logic drain;
    logic stall;
    logic xfer;
    logic load;

    function automatic logic [stream_pkg::COUNT_WIDTH-1:0] count_keep(
        input logic [stream_pkg::KEEP_WIDTH-1:0] keep
    );
        logic [stream_pkg::COUNT_WIDTH-1:0] n;
        n = '0;
        for (int i = 0; i < stream_pkg::KEEP_WIDTH; i++) begin
            if (keep[i]) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign beat_bytes = count_keep(buf_beat.keep);

    assign drain = stat_valid && stat_ready_reg;
    // last beat waits while the summary slot is busy
    assign stall = buf_beat.last && stat_valid && !drain;

    assign out_tdata  = buf_beat.data;
    assign out_tkeep  = buf_beat.keep;
    assign out_tlast  = buf_beat.last;
    assign out_tuser  = buf_beat.user;
    assign out_tsrc   = buf_beat.src;
    assign out_tvalid = buf_valid && !stall;
    assign buf_ready  = out_tready && !stall;

    assign xfer = buf_valid && buf_ready;
    assign load = xfer && buf_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            stat_valid     <= 1'b0;
            stat_ready_reg <= 1'b0;
            beat_cnt       <= '0;
            byte_cnt       <= '0;
            err_acc        <= 1'b0;
        end else begin
            stat_ready_reg <= stat_ready;
            if (load) begin
                stat_valid <= 1'b1;
            end else if (drain) begin
                stat_valid <= 1'b0;
            end
            if (load) begin
                beat_cnt <= '0;
                byte_cnt <= '0;
                err_acc  <= 1'b0;
            end else if (xfer) begin
                beat_cnt <= beat_cnt + 1'b1;
                byte_cnt <= byte_cnt + beat_bytes;
                err_acc  <= err_acc || buf_beat.user;
            end
        end
    end

    // summary record including the last beat itself
    always_ff @(posedge clk) begin
        if (load) begin
            stat_summary.src   <= buf_beat.src;
            stat_summary.beats <= beat_cnt + 1'b1;
            stat_summary.bytes <= byte_cnt + beat_bytes;
            stat_summary.err   <= err_acc || buf_beat.user;
        end
    end

    a_no_summary_overwrite: assert property (
        @(posedge clk) disable iff (rst)
        stat_valid && !drain |=> stat_valid && $stable(stat_summary)
    );

endmodule

`default_nettype wire

// File: src/stream_frame_mux.sv
/*
  four-input frame multiplexer. select is sampled only when idle and is held
  until the last beat of the granted frame is accepted.
  in_tready is registered from the downstream early ready, so the downstream
  stage must accept one beat after it lowers its early ready.
*/

`default_nettype none

module stream_frame_mux (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  enable,
    input  wire  [stream_pkg::SEL_WIDTH-1:0]     select,

    input  wire  [stream_pkg::DATA_WIDTH-1:0]    in_tdata  [stream_pkg::PORT_COUNT],
    input  wire  [stream_pkg::KEEP_WIDTH-1:0]    in_tkeep  [stream_pkg::PORT_COUNT],
    input  wire                                  in_tvalid [stream_pkg::PORT_COUNT],
    input  wire                                  in_tlast  [stream_pkg::PORT_COUNT],
    input  wire                                  in_tuser  [stream_pkg::PORT_COUNT],
    output logic                                 in_tready [stream_pkg::PORT_COUNT],

    output logic                                 mux_valid,
    output stream_pkg::beat_t                    mux_beat,
    input  wire                                  mux_ready_early
);

    logic [stream_pkg::SEL_WIDTH-1:0] sel_reg;
    logic [stream_pkg::SEL_WIDTH-1:0] sel_next;
    logic                             frame_reg;
    logic                             frame_next;
    logic                             ready_next [stream_pkg::PORT_COUNT];

    // valid of the selected port starts a frame
    logic select_valid;

    // handshake of the latched port
    logic cur_valid;
    logic cur_ready;
    logic cur_last;

    assign select_valid = in_tvalid[select];

    assign cur_valid = in_tvalid[sel_reg];
    assign cur_ready = in_tready[sel_reg];
    assign cur_last  = in_tlast[sel_reg];

    // frame tracking
    always_comb begin
        sel_next   = sel_reg;
        frame_next = frame_reg;

        if (frame_reg) begin
            // frame closes when its last beat is taken
            if (cur_valid && cur_ready) begin
                frame_next = !cur_last;
            end
        end else if (enable && select_valid) begin
            // grab select at start of frame
            frame_next = 1'b1;
            sel_next   = select;
        end
    end

    // one-hot ready toward the port that owns the next cycle
    always_comb begin
        for (int p = 0; p < stream_pkg::PORT_COUNT; p++) begin
            ready_next[p] = frame_next && mux_ready_early && (int'(sel_next) == p);
        end
    end

    // forward the latched port tagged with its index
    always_comb begin
        mux_beat.data = in_tdata[sel_reg];
        mux_beat.keep = in_tkeep[sel_reg];
        mux_beat.last = cur_last;
        mux_beat.user = in_tuser[sel_reg];
        mux_beat.src  = sel_reg;
    end

    assign mux_valid = cur_valid && cur_ready && frame_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg   <= '0;
            frame_reg <= 1'b0;
            for (int p = 0; p < stream_pkg::PORT_COUNT; p++) begin
                in_tready[p] <= 1'b0;
            end
        end else begin
            sel_reg   <= sel_next;
            frame_reg <= frame_next;
            for (int p = 0; p < stream_pkg::PORT_COUNT; p++) begin
                in_tready[p] <= ready_next[p];
            end
        end
    end

    // a frame stays open on its port until the last beat has gone downstream
    a_sel_held_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        frame_reg && !(mux_valid && mux_beat.last) |=> frame_reg && sel_reg == $past(sel_reg)
    );

endmodule

`default_nettype wire

// File: src/stream_mux_top.sv
/*
  four-port frame multiplexer with a registered beat output and a per-frame
  summary stream. select is honored only between frames.
  both outputs use valid/ready and may stall each other through frame_stats.
*/

`default_nettype none

module stream_mux_top (
    input  wire                                  clk,
    input  wire                                  rst,

    // control
    input  wire                                  enable,
    input  wire  [stream_pkg::SEL_WIDTH-1:0]     select,

    // input ports
    input  wire  [stream_pkg::DATA_WIDTH-1:0]    in_tdata  [stream_pkg::PORT_COUNT],
    input  wire  [stream_pkg::KEEP_WIDTH-1:0]    in_tkeep  [stream_pkg::PORT_COUNT],
    input  wire                                  in_tvalid [stream_pkg::PORT_COUNT],
    input  wire                                  in_tlast  [stream_pkg::PORT_COUNT],
    input  wire                                  in_tuser  [stream_pkg::PORT_COUNT],
    output logic                                 in_tready [stream_pkg::PORT_COUNT],

    // beat output
    output logic [stream_pkg::DATA_WIDTH-1:0]    out_tdata,
    output logic [stream_pkg::KEEP_WIDTH-1:0]    out_tkeep,
    output logic                                 out_tvalid,
    input  wire                                  out_tready,
    output logic                                 out_tlast,
    output logic                                 out_tuser,
    output logic [stream_pkg::SEL_WIDTH-1:0]     out_tsrc,

    // summary output
    output logic                                 sum_valid,
    input  wire                                  sum_ready,
    output logic [stream_pkg::SEL_WIDTH-1:0]     sum_src,
    output logic [stream_pkg::COUNT_WIDTH-1:0]   sum_beats,
    output logic [stream_pkg::COUNT_WIDTH-1:0]   sum_bytes,
    output logic                                 sum_err
);

    // mux to beat buffer
    logic                       mux_valid;
    stream_pkg::beat_t          mux_beat;
    logic                       mux_ready_early;

    // beat buffer to stats
    logic                       buf_valid;
    stream_pkg::beat_t          buf_beat;
    logic                       buf_ready;

    // stats to summary buffer
    logic                       stat_valid;
    stream_pkg::frame_summary_t stat_summary;
    logic                       stat_ready;

    stream_pkg::frame_summary_t sum_summary;

    assign sum_src   = sum_summary.src;
    assign sum_beats = sum_summary.beats;
    assign sum_bytes = sum_summary.bytes;
    assign sum_err   = sum_summary.err;

    stream_frame_mux mux_inst (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .select          (select),
        .in_tdata        (in_tdata),
        .in_tkeep        (in_tkeep),
        .in_tvalid       (in_tvalid),
        .in_tlast        (in_tlast),
        .in_tuser        (in_tuser),
        .in_tready       (in_tready),
        .mux_valid       (mux_valid),
        .mux_beat        (mux_beat),
        .mux_ready_early (mux_ready_early)
    );

    stream_skid_buffer #(
        .payload_t (stream_pkg::beat_t)
    ) beat_buffer (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (mux_valid),
        .in_payload     (mux_beat),
        .in_ready_early (mux_ready_early),
        .out_valid      (buf_valid),
        .out_payload    (buf_beat),
        .out_ready      (buf_ready)
    );

    frame_stats stats_inst (
        .clk          (clk),
        .rst          (rst),
        .buf_valid    (buf_valid),
        .buf_beat     (buf_beat),
        .buf_ready    (buf_ready),
        .out_tdata    (out_tdata),
        .out_tkeep    (out_tkeep),
        .out_tvalid   (out_tvalid),
        .out_tlast    (out_tlast),
        .out_tuser    (out_tuser),
        .out_tsrc     (out_tsrc),
        .out_tready   (out_tready),
        .stat_valid   (stat_valid),
        .stat_summary (stat_summary),
        .stat_ready   (stat_ready)
    );

    // early ready goes straight to frame_stats, which registers it
    stream_skid_buffer #(
        .payload_t (stream_pkg::frame_summary_t)
    ) summary_buffer (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (stat_valid),
        .in_payload     (stat_summary),
        .in_ready_early (stat_ready),
        .out_valid      (sum_valid),
        .out_payload    (sum_summary),
        .out_ready      (sum_ready)
    );

endmodule

`default_nettype wire

// File: src/stream_pkg.sv
/*
  shared widths and record types for the four-port stream multiplexer.
  all widths are fixed here; modules do not override them.
*/

`default_nettype none

package stream_pkg;

    // beat datapath
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // input ports and the width of an index into them
    localparam int PORT_COUNT = 4;
    localparam int SEL_WIDTH  = 2;

    // frame statistics counters, wrap silently on overflow
    localparam int COUNT_WIDTH = 16;

    // one beat after the mux, tagged with its source port
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic                  user;
        logic [SEL_WIDTH-1:0]  src;
    } beat_t;

    // one record per completed frame
    typedef struct packed {
        logic [SEL_WIDTH-1:0]   src;
        logic [COUNT_WIDTH-1:0] beats;
        logic [COUNT_WIDTH-1:0] bytes;
        logic                   err;
    } frame_summary_t;

endpackage

`default_nettype wire

// File: src/stream_skid_buffer.sv
/*
  two-entry registered stage with an early ready.
  the upstream side must treat in_ready_early as a ready for the next cycle;
  in_valid is sampled only while the registered copy of that ready is high.
*/

`default_nettype none

module stream_skid_buffer #(
    parameter type payload_t = logic
) (
    input  wire       clk,
    input  wire       rst,

    input  wire       in_valid,
    input  wire       payload_t in_payload,
    output logic      in_ready_early,

    output logic      out_valid,
    output payload_t  out_payload,
    input  wire       out_ready
);

    logic     in_ready_reg;
    logic     temp_valid;
    payload_t temp_payload;

    logic out_valid_next;
    logic temp_valid_next;
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // ready next cycle unless the temp register would fill
    assign in_ready_early = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready_reg) begin
            if (out_ready || !out_valid) begin
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            temp_valid   <= 1'b0;
            in_ready_reg <= 1'b0;
        end else begin
            out_valid    <= out_valid_next;
            temp_valid   <= temp_valid_next;
            in_ready_reg <= in_ready_early;
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_payload <= in_payload;
        end else if (store_temp_to_out) begin
            out_payload <= temp_payload;
        end
        if (store_in_to_temp) begin
            temp_payload <= in_payload;
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_payload)
    );

endmodule

`default_nettype wire

// File: test/stream_mux_tb.sv
/*
  directed testbench for the stream multiplexer. frames come from an LFSR and
  are expected in grant order, so select only moves between frames or on
  purpose in the middle of one. inputs change on the falling clock edge.
*/

`default_nettype none

module stream_mux_tb;

    logic                                 clk;
    logic                                 rst;
    logic                                 enable;
    logic [stream_pkg::SEL_WIDTH-1:0]     select;
    logic [stream_pkg::DATA_WIDTH-1:0]    in_tdata  [stream_pkg::PORT_COUNT];
    logic [stream_pkg::KEEP_WIDTH-1:0]    in_tkeep  [stream_pkg::PORT_COUNT];
    logic                                 in_tvalid [stream_pkg::PORT_COUNT];
    logic                                 in_tlast  [stream_pkg::PORT_COUNT];
    logic                                 in_tuser  [stream_pkg::PORT_COUNT];
    logic                                 in_tready [stream_pkg::PORT_COUNT];
    logic [stream_pkg::DATA_WIDTH-1:0]    out_tdata;
    logic [stream_pkg::KEEP_WIDTH-1:0]    out_tkeep;
    logic                                 out_tvalid;
    logic                                 out_tready;
    logic                                 out_tlast;
    logic                                 out_tuser;
    logic [stream_pkg::SEL_WIDTH-1:0]     out_tsrc;
    logic                                 sum_valid;
    logic                                 sum_ready;
    logic [stream_pkg::SEL_WIDTH-1:0]     sum_src;
    logic [stream_pkg::COUNT_WIDTH-1:0]   sum_beats;
    logic [stream_pkg::COUNT_WIDTH-1:0]   sum_bytes;
    logic                                 sum_err;

    // frames of the running test, stored in grant order
    stream_pkg::beat_t                    beat_mem    [0:255];
    logic [stream_pkg::SEL_WIDTH-1:0]     frame_port  [0:31];
    int                                   frame_start [0:31];
    int                                   frame_len   [0:31];
    int                                   frame_count;
    int                                   beat_total;
    stream_pkg::beat_t                    exp_beats [$];
    stream_pkg::frame_summary_t           exp_sums  [$];

    logic [31:0] lfsr_state;
    int          error_count;
    int          errors_before;
    int          tests_run;
    int          tests_failed;
    bit          traffic_done;

    tb_clock_gen clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    stream_mux_top stream_mux_top_inst (.*);

    // galois LFSR, one step for every bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int rand_len();
        return 1 + int'(rand_bits(3));
    endfunction

    function automatic int count_bits(input logic [stream_pkg::KEEP_WIDTH-1:0] keep);
        int n;
        n = 0;
        for (int i = 0; i < stream_pkg::KEEP_WIDTH; i++) begin
            n = n + int'(keep[i]);
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            $display("FAILED %s expected %h got %h", name, want, got);
            error_count++;
        end
    endtask

    // one frame plus its expected beats and summary
    task automatic add_frame(input logic [stream_pkg::SEL_WIDTH-1:0] port, input int len);
        stream_pkg::beat_t          beat;
        stream_pkg::frame_summary_t summary;
        int                         n;
        summary = '0;
        frame_port[frame_count]  = port;
        frame_start[frame_count] = beat_total;
        frame_len[frame_count]   = len;
        for (int b = 0; b < len; b++) begin
            beat.data = rand_bits(64);
            beat.last = (b == len - 1);
            // partial keep only on the last beat, low bytes first
            n = beat.last ? rand_len() : 8;
            beat.keep = 8'hff >> (8 - n);
            beat.user = (rand_bits(3) == 0);
            beat.src  = port;
            beat_mem[beat_total] = beat;
            exp_beats.push_back(beat);
            beat_total++;
            summary.bytes = summary.bytes + stream_pkg::COUNT_WIDTH'(count_bits(beat.keep));
            summary.err   = summary.err | beat.user;
        end
        summary.src   = port;
        summary.beats = stream_pkg::COUNT_WIDTH'(len);
        exp_sums.push_back(summary);
        frame_count++;
    endtask

    // offers this port's frames, holding each beat until it is taken
    task automatic drive_port(input int p);
        stream_pkg::beat_t beat;
        for (int k = 0; k < frame_count; k++) begin
            if (int'(frame_port[k]) == p) begin
                for (int b = 0; b < frame_len[k]; b++) begin
                    beat = beat_mem[frame_start[k] + b];
                    @(negedge clk);
                    in_tvalid[p] = 1'b1;
                    in_tdata[p]  = beat.data;
                    in_tkeep[p]  = beat.keep;
                    in_tlast[p]  = beat.last;
                    in_tuser[p]  = beat.user;
                    do begin
                        @(posedge clk);
                    end while (!in_tready[p]);
                end
            end
        end
        @(negedge clk);
        in_tvalid[p] = 1'b0;
    endtask

    task automatic wait_input_beat(input int p, input bit need_last);
        do begin
            @(posedge clk);
        end while (!(in_tvalid[p] && in_tready[p] && (in_tlast[p] || !need_last)));
    endtask

    // select follows the frame order, optionally moving on after the first beat
    task automatic steer_select(input bit early_switch);
        int p;
        for (int k = 0; k < frame_count; k++) begin
            p = int'(frame_port[k]);
            @(negedge clk);
            select = frame_port[k];
            if (early_switch && k + 1 < frame_count && frame_len[k] > 1) begin
                wait_input_beat(p, 1'b0);
                @(negedge clk);
                select = frame_port[k + 1];
            end
            wait_input_beat(p, 1'b1);
        end
    endtask

    // mode 0 always ready, 1 gaps on beats, 2 gaps on beats and summaries
    task automatic pace_ready(input int mode);
        while (!traffic_done) begin
            @(negedge clk);
            out_tready = (mode == 0) || (rand_bits(2) != 0);
            sum_ready  = (mode != 2) || (rand_bits(2) == 0);
        end
        out_tready = 1'b1;
        sum_ready  = 1'b1;
    endtask

    task automatic watch_beats();
        stream_pkg::beat_t want;
        while (exp_beats.size() > 0) begin
            @(posedge clk);
            if (out_tvalid && out_tready) begin
                want = exp_beats.pop_front();
                check_value("out_tdata", out_tdata, want.data);
                check_value("out_tkeep", out_tkeep, want.keep);
                check_value("out_tlast", out_tlast, want.last);
                check_value("out_tuser", out_tuser, want.user);
                check_value("out_tsrc", out_tsrc, want.src);
            end
        end
    endtask

    task automatic watch_sums();
        stream_pkg::frame_summary_t want;
        while (exp_sums.size() > 0) begin
            @(posedge clk);
            if (sum_valid && sum_ready) begin
                want = exp_sums.pop_front();
                check_value("sum_src", sum_src, want.src);
                check_value("sum_beats", sum_beats, want.beats);
                check_value("sum_bytes", sum_bytes, want.bytes);
                check_value("sum_err", sum_err, want.err);
            end
        end
    endtask

    task automatic run_frames(input int mode, input bit early_switch);
        @(negedge clk);
        traffic_done = 1'b0;
        select = frame_port[0];
        fork
            drive_port(0);
            drive_port(1);
            drive_port(2);
            drive_port(3);
            steer_select(early_switch);
            pace_ready(mode);
            begin
                fork
                    watch_beats();
                    watch_sums();
                join
                traffic_done = 1'b1;
            end
        join
        // nothing may follow the expected traffic
        repeat (10) begin
            @(posedge clk);
            check_value("out_tvalid", out_tvalid, 0);
            check_value("sum_valid", sum_valid, 0);
        end
    endtask

    task automatic start_test();
        frame_count = 0;
        beat_total  = 0;
        exp_beats.delete();
        exp_sums.delete();
        errors_before = error_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic reset_and_disable();
        start_test();
        check_value("out_tvalid", out_tvalid, 0);
        check_value("sum_valid", sum_valid, 0);
        select       = 2'd2;
        in_tvalid[2] = 1'b1;
        in_tlast[2]  = 1'b1;
        repeat (20) begin
            @(posedge clk);
            for (int p = 0; p < stream_pkg::PORT_COUNT; p++) begin
                check_value($sformatf("in_tready[%0d]", p), in_tready[p], 0);
            end
            check_value("out_tvalid", out_tvalid, 0);
        end
        @(negedge clk);
        in_tvalid[2] = 1'b0;
        in_tlast[2]  = 1'b0;
        @(negedge clk);
        enable = 1'b1;
        end_test("reset and disabled mux");
    endtask

    task automatic frames_per_port();
        start_test();
        for (int p = 0; p < stream_pkg::PORT_COUNT; p++) begin
            add_frame(stream_pkg::SEL_WIDTH'(p), rand_len());
        end
        run_frames(0, 1'b0);
        end_test("one frame per port");
    endtask

    task automatic select_mid_frame();
        start_test();
        add_frame(2'd1, 5);
        add_frame(2'd3, rand_len());
        add_frame(2'd0, rand_len());
        run_frames(0, 1'b1);
        end_test("select change inside a frame");
    endtask

    task automatic mixed_frames(input string name, input int mode, input int len_bits);
        start_test();
        for (int k = 0; k < 12; k++) begin
            add_frame(stream_pkg::SEL_WIDTH'(rand_bits(2)), 1 + int'(rand_bits(len_bits)));
        end
        run_frames(mode, 1'b0);
        end_test(name);
    endtask

    initial begin
        lfsr_state   = 32'hfe70;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        traffic_done = 1'b0;
        enable       = 1'b0;
        select       = '0;
        out_tready   = 1'b1;
        sum_ready    = 1'b1;
        for (int p = 0; p < stream_pkg::PORT_COUNT; p++) begin
            in_tdata[p]  = '0;
            in_tkeep[p]  = '0;
            in_tvalid[p] = 1'b0;
            in_tlast[p]  = 1'b0;
            in_tuser[p]  = 1'b0;
        end
        wait (rst == 1'b0);
        @(negedge clk);
        reset_and_disable();
        frames_per_port();
        select_mid_frame();
        mixed_frames("frames under beat back-pressure", 1, 3);
        // short frames keep the summary path busy
        mixed_frames("summaries under back-pressure", 2, 1);
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // 31 frames of at most 8 beats, 40 cycles per beat, plus idle checks
    initial begin
        int limit;
        limit = 31 * 8 * 40 + 500;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, traffic stopped moving", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
/*
  testbench clock and reset. period of 100 time units, reset held high
  for the first 4 rising edges and released on a falling edge.
*/

`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

`default_nettype wire
